// File: rtl/entropy_decoder_config.svh
/*
 * Entropy decoder build constants
 * Block geometry, header length, width code packing, bit buffer size
 * and the idle gap between blocks
 */
`ifndef ENTROPY_DECODER_CONFIG_SVH
`define ENTROPY_DECODER_CONFIG_SVH

// Coefficients in one 8x8 block
`define BLOCK_COEFS 64

// Run count byte, unused byte, DC byte
`define HEADER_BYTES 3

// Payload values covered by one width code
`define GROUP_SIZE 4

// Two-bit width codes packed in one width byte
`define CODES_PER_WORD 4

// Payload bit buffer in the unpacker
`define BUFFER_BITS 16

// Idle cycles after block_done before the next block
`define BLOCK_GAP_CYCLES 4

`endif

// File: rtl/entropy_decoder_pkg.sv
/*
 * Entropy decoder shared types
 * Stream and coefficient types, block header record, sequencer stages
 * and the scan step to block position table
 */
`default_nettype none

package entropy_decoder_pkg;

`include "entropy_decoder_config.svh"

    typedef logic [7:0] byte_t;
    typedef logic signed [7:0] coef_t;
    typedef logic [5:0] scan_index_t;
    typedef logic [5:0] run_count_t;
    typedef logic [1:0] width_code_t;

    // Fields kept from the three header bytes
    typedef struct packed {
        run_count_t run_count;
        coef_t      dc_value;
    } block_header_t;

    // Idle until armed, then wait, start and busy once per block
    typedef enum logic [1:0] {
        STAGE_IDLE  = 2'b00,
        STAGE_WAIT  = 2'b01,
        STAGE_START = 2'b11,
        STAGE_BUSY  = 2'b10
    } dec_stage_t;

    // ----------------------------------------------------------------
    // Scan order, step 0 is the DC position
    // ----------------------------------------------------------------
    localparam scan_index_t SCAN_TABLE [0:`BLOCK_COEFS-1] = '{
         0, 40, 33, 26, 19, 12,  5,  4,
        11, 18, 25, 32, 24, 17, 10,  3,
         2,  9, 16,  8,  1, 63, 62, 55,
        47, 54, 61, 60, 53, 46, 39, 31,
        38, 45, 52, 59, 58, 51, 44, 37,
        30, 23, 15, 22, 29, 36, 43, 50,
        57, 56, 49, 42, 35, 28, 21, 14,
         7,  6, 13, 20, 27, 34, 41, 48
    };

    function automatic scan_index_t scan_position(input scan_index_t step);
        return SCAN_TABLE[step];
    endfunction

endpackage

`default_nettype wire

// File: rtl/block_sequencer.sv
/*
 * Block sequencer
 * Arms on a start pulse, launches one block when source and sink are
 * both ready, then holds off for a fixed gap after the block ends
 */
`timescale 1ns/1ps
`default_nettype none
`include "entropy_decoder_config.svh"

module block_sequencer (
    input  logic clock,
    input  logic reset_n,
    input  logic decompress_start,
    input  logic enc_data_ready,
    input  logic dec_data_fifo_ready,
    input  logic block_done,
    output logic block_start
);
    import entropy_decoder_pkg::*;

    localparam int GAP_W = $clog2(`BLOCK_GAP_CYCLES + 1);
    localparam logic [GAP_W-1:0] GAP_LOAD = GAP_W'(`BLOCK_GAP_CYCLES);

    dec_stage_t       stage;
    logic [GAP_W-1:0] gap_count;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            stage     <= STAGE_IDLE;
            gap_count <= '0;
        end else begin
            case (stage)
                STAGE_IDLE: begin
                    if (decompress_start) begin
                        stage <= STAGE_WAIT;
                    end
                end
                STAGE_WAIT: begin
                    if (enc_data_ready && dec_data_fifo_ready) begin
                        stage <= STAGE_START;
                    end
                end
                STAGE_START: begin
                    stage <= STAGE_BUSY;
                end
                STAGE_BUSY: begin
                    // Gap counter only runs once the block has finished
                    if (block_done) begin
                        gap_count <= GAP_LOAD;
                    end else if (gap_count != '0) begin
                        gap_count <= gap_count - 1'b1;
                        if (gap_count == GAP_W'(1)) begin
                            stage <= STAGE_WAIT;
                        end
                    end
                end
                default: begin
                    stage <= STAGE_IDLE;
                end
            endcase
        end
    end

    assign block_start = (stage == STAGE_START);

endmodule

`default_nettype wire

// File: rtl/header_parser.sv
/*
 * Block header parser
 * Requests the header bytes of each block and keeps the run count
 * from byte 0 and the DC value from byte 2
 */
`timescale 1ns/1ps
`default_nettype none
`include "entropy_decoder_config.svh"

module header_parser (
    input  logic                               clock,
    input  logic                               reset_n,
    input  logic                               block_start,
    input  logic                               enc_data_ready,
    input  entropy_decoder_pkg::byte_t         enc_data,
    output logic                               header_req,
    output entropy_decoder_pkg::block_header_t header,
    output logic                               header_done
);
    localparam int COUNT_W = $clog2(`HEADER_BYTES);
    localparam logic [COUNT_W-1:0] RUN_BYTE  = '0;
    localparam logic [COUNT_W-1:0] DC_BYTE   = COUNT_W'(2);
    localparam logic [COUNT_W-1:0] LAST_BYTE = COUNT_W'(`HEADER_BYTES - 1);

    logic [COUNT_W-1:0] byte_count;
    logic               take;
    logic               last_take;

    assign take      = header_req && enc_data_ready;
    assign last_take = take && (byte_count == LAST_BYTE);

    // ----------------------------------------------------------------
    // Request and byte counter
    // ----------------------------------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            header_req  <= 1'b0;
            byte_count  <= '0;
            header_done <= 1'b0;
        end else begin
            header_done <= last_take;
            if (block_start) begin
                header_req <= 1'b1;
                byte_count <= '0;
            end else if (take) begin
                byte_count <= byte_count + 1'b1;
                if (last_take) begin
                    header_req <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------------
    // Header registers
    // ----------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (take) begin
            // Flag bits 1..0 of byte 0 carry nothing in this format
            if (byte_count == RUN_BYTE) begin
                header.run_count <= enc_data[7:2];
            end
            if (byte_count == DC_BYTE) begin
                header.dc_value <= enc_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/coefficient_unpacker.sv
/*
 * Coefficient unpacker
 * Loads the width codes, then pulls payload bytes into a bit buffer
 * and cuts out one sign-extended field per value
 */
`timescale 1ns/1ps
`default_nettype none
`include "entropy_decoder_config.svh"

module coefficient_unpacker (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            block_start,
    input  logic                            header_done,
    input  logic                            payload_start,
    input  logic                            enc_data_ready,
    input  entropy_decoder_pkg::byte_t      enc_data,
    input  entropy_decoder_pkg::run_count_t run_count,
    output logic                            payload_req,
    output entropy_decoder_pkg::coef_t      coef_value,
    output logic                            coef_valid
);
    import entropy_decoder_pkg::*;

    localparam int MAX_VALUES = `BLOCK_COEFS - 1;
    localparam int MAX_GROUPS = (MAX_VALUES + `GROUP_SIZE - 1) / `GROUP_SIZE;
    localparam int MAX_WORDS  = (MAX_GROUPS + `CODES_PER_WORD - 1) / `CODES_PER_WORD;
    localparam int CODE_BITS  = $bits(width_code_t);
    localparam int FIELD_BITS = 1 << CODE_BITS;
    localparam int WORD_BITS  = $bits(byte_t);
    localparam int CODES_W    = MAX_WORDS * `CODES_PER_WORD * CODE_BITS;
    localparam int GROUP_W    = $clog2(MAX_GROUPS + 1);
    localparam int WORD_W     = $clog2(MAX_WORDS + 1);
    localparam int POS_W      = $clog2(`GROUP_SIZE);
    localparam int FILL_W     = $clog2(`BUFFER_BITS + 1);
    localparam run_count_t LAST_STEP      = run_count_t'(MAX_VALUES);
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(`GROUP_SIZE - 1);

    run_count_t              n_values;
    logic [GROUP_W-1:0]      n_groups;
    logic [WORD_W-1:0]       n_words;
    run_count_t              values_left;
    logic [WORD_W-1:0]       word_total;
    logic [WORD_W-1:0]       word_count;
    logic [POS_W-1:0]        group_pos;
    logic [FILL_W-1:0]       fill;
    logic                    armed;
    logic [CODES_W-1:0]      code_reg;
    logic [`BUFFER_BITS-1:0] bit_buf;
    width_code_t             cur_code;
    logic [CODE_BITS:0]      cur_width;
    logic                    codes_loading;
    logic                    codes_ready;
    logic                    fill_req;
    logic                    take;
    logic [FIELD_BITS-1:0]   field;
    coef_t                   field_ext;

    // Payload size of the block, rounded up to whole groups and words
    always_comb begin
        n_values = LAST_STEP - run_count;
        n_groups = GROUP_W'((int'(n_values) + `GROUP_SIZE - 1) / `GROUP_SIZE);
        n_words  = WORD_W'((int'(n_groups) + `CODES_PER_WORD - 1) / `CODES_PER_WORD);
    end

    assign cur_code  = code_reg[CODES_W-1 -: CODE_BITS];
    assign cur_width = {1'b0, cur_code} + 1'b1;

    assign codes_loading = (word_count != word_total);
    assign codes_ready   = !codes_loading && (values_left != '0);
    // Fetch only when the next field is not fully in the buffer
    assign fill_req      = codes_ready && (fill < cur_width);
    assign coef_valid    = armed && codes_ready && (fill >= cur_width);
    assign payload_req   = codes_loading || fill_req;
    assign take          = payload_req && enc_data_ready;

    // Top FIELD_BITS of the buffer, shifted down to the current width
    assign field      = bit_buf[`BUFFER_BITS-1 -: FIELD_BITS];
    assign field_ext  = {{($bits(coef_t) - FIELD_BITS){field[FIELD_BITS-1]}}, field};
    assign coef_value = field_ext >>> (FIELD_BITS - cur_width);

    // ----------------------------------------------------------------
    // Block counters
    // ----------------------------------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            values_left <= '0;
            word_total  <= '0;
            word_count  <= '0;
            group_pos   <= '0;
            fill        <= '0;
            armed       <= 1'b0;
        end else if (block_start) begin
            values_left <= '0;
            word_total  <= '0;
            word_count  <= '0;
            group_pos   <= '0;
            fill        <= '0;
            armed       <= 1'b0;
        end else begin
            if (header_done) begin
                values_left <= n_values;
                word_total  <= n_words;
            end
            if (payload_start) begin
                armed <= 1'b1;
            end
            if (take && codes_loading) begin
                word_count <= word_count + 1'b1;
            end
            if (take && fill_req) begin
                fill <= fill + FILL_W'(WORD_BITS);
            end
            if (coef_valid) begin
                values_left <= values_left - 1'b1;
                fill        <= fill - cur_width;
                group_pos   <= (group_pos == LAST_POS) ? '0 : group_pos + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------
    // Width codes and payload bits
    // ----------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (take && codes_loading) begin
            code_reg[CODES_W-1 - WORD_BITS*word_count -: WORD_BITS] <= enc_data;
        end else if (coef_valid && (group_pos == LAST_POS)) begin
            code_reg <= code_reg << CODE_BITS;
        end
        // New byte lands right below the bits still waiting
        if (take && fill_req) begin
            bit_buf[`BUFFER_BITS-1 - fill -: WORD_BITS] <= enc_data;
        end else if (coef_valid) begin
            bit_buf <= bit_buf << cur_width;
        end
    end

endmodule

`default_nettype wire

// File: rtl/coefficient_output.sv
/*
 * Coefficient output stage
 * Sends DC, the zero run and the unpacked values in scan order, each
 * tagged with its block position, and flags the end of the block
 */
`timescale 1ns/1ps
`default_nettype none
`include "entropy_decoder_config.svh"

module coefficient_output (
    input  logic                               clock,
    input  logic                               reset_n,
    input  logic                               block_start,
    input  logic                               header_done,
    input  entropy_decoder_pkg::block_header_t header,
    input  entropy_decoder_pkg::coef_t         coef_value,
    input  logic                               coef_valid,
    output logic                               payload_start,
    output entropy_decoder_pkg::coef_t         dec_data,
    output entropy_decoder_pkg::scan_index_t   dec_data_index,
    output logic                               dec_data_en,
    output logic                               block_done
);
    import entropy_decoder_pkg::*;

    localparam int STEP_W = $clog2(`BLOCK_COEFS + 1);
    localparam logic [STEP_W-1:0] LAST_COUNT = STEP_W'(`BLOCK_COEFS);
    localparam run_count_t FULL_RUN = run_count_t'(`BLOCK_COEFS - 1);

    logic [STEP_W-1:0] step;
    run_count_t        zero_left;
    logic              zero_active;
    logic              emit;

    // DC, zeros and payload never overlap in time
    assign emit = header_done || zero_active || coef_valid;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            step          <= '0;
            zero_left     <= '0;
            zero_active   <= 1'b0;
            payload_start <= 1'b0;
            dec_data_en   <= 1'b0;
            block_done    <= 1'b0;
        end else begin
            dec_data_en   <= emit;
            block_done    <= dec_data_en && (step == LAST_COUNT);
            payload_start <= (header_done && (header.run_count == '0))
                          || (zero_active && (zero_left == 6'd1)
                              && (header.run_count != FULL_RUN));
            if (block_start) begin
                step <= '0;
            end else if (emit) begin
                step <= step + 1'b1;
            end
            if (header_done) begin
                zero_left   <= header.run_count;
                zero_active <= (header.run_count != '0);
            end else if (zero_active) begin
                zero_left   <= zero_left - 1'b1;
                zero_active <= (zero_left != 6'd1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (emit) begin
            dec_data_index <= scan_position(scan_index_t'(step));
            if (header_done) begin
                dec_data <= header.dc_value;
            end else if (zero_active) begin
                dec_data <= '0;
            end else begin
                dec_data <= coef_value;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/entropy_decoder.sv
/*
 * Entropy decoder top level
 * Restores the 64 coefficients of one compressed 8x8 block at a time
 * from a byte stream, with a scan position tag on each output
 */
`timescale 1ns/1ps
`default_nettype none

module entropy_decoder (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic                             decompress_start,
    input  logic                             enc_data_ready,
    input  entropy_decoder_pkg::byte_t       enc_data,
    input  logic                             dec_data_fifo_ready,
    output logic                             enc_data_req,
    output entropy_decoder_pkg::coef_t       dec_data,
    output logic                             dec_data_en,
    output entropy_decoder_pkg::scan_index_t dec_data_index
);
    import entropy_decoder_pkg::*;

    logic          block_start;
    logic          header_req;
    logic          header_done;
    logic          payload_req;
    logic          payload_start;
    logic          coef_valid;
    logic          block_done;
    block_header_t header;
    coef_t         coef_value;

    // Header and payload phases take turns on the byte stream
    assign enc_data_req = header_req | payload_req;

    block_sequencer sequencer_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .decompress_start    (decompress_start),
        .enc_data_ready      (enc_data_ready),
        .dec_data_fifo_ready (dec_data_fifo_ready),
        .block_done          (block_done),
        .block_start         (block_start)
    );

    header_parser parser_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .block_start    (block_start),
        .enc_data_ready (enc_data_ready),
        .enc_data       (enc_data),
        .header_req     (header_req),
        .header         (header),
        .header_done    (header_done)
    );

    coefficient_unpacker unpacker_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .block_start    (block_start),
        .header_done    (header_done),
        .payload_start  (payload_start),
        .enc_data_ready (enc_data_ready),
        .enc_data       (enc_data),
        .run_count      (header.run_count),
        .payload_req    (payload_req),
        .coef_value     (coef_value),
        .coef_valid     (coef_valid)
    );

    coefficient_output output_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .block_start    (block_start),
        .header_done    (header_done),
        .header         (header),
        .coef_value     (coef_value),
        .coef_valid     (coef_valid),
        .payload_start  (payload_start),
        .dec_data       (dec_data),
        .dec_data_index (dec_data_index),
        .dec_data_en    (dec_data_en),
        .block_done     (block_done)
    );

endmodule

`default_nettype wire

// File: bench/tb_entropy_decoder.sv
/*
 * Entropy decoder testbench
 * Encodes blocks into one byte stream, feeds it to the decoder with and
 * without source stalls, and checks every output against a reference
 * decode of the same stream
 */
`timescale 1ns/1ps
`default_nettype none
`include "entropy_decoder_config.svh"

module tb_entropy_decoder;
    import entropy_decoder_pkg::*;

    localparam int SEED           = 91719;
    localparam int NUM_BLOCKS     = 12;
    localparam int MAX_VALUES     = `BLOCK_COEFS - 1;
    localparam int CODES_PER_BYTE = `GROUP_SIZE * `CODES_PER_WORD;
    localparam int TIMEOUT_CYCLES = 200 * NUM_BLOCKS + 100;

    // Block scan order of the stream format, step 0 holds DC
    localparam int SCAN_ORDER [0:`BLOCK_COEFS-1] = '{
         0, 40, 33, 26, 19, 12,  5,  4,
        11, 18, 25, 32, 24, 17, 10,  3,
         2,  9, 16,  8,  1, 63, 62, 55,
        47, 54, 61, 60, 53, 46, 39, 31,
        38, 45, 52, 59, 58, 51, 44, 37,
        30, 23, 15, 22, 29, 36, 43, 50,
        57, 56, 49, 42, 35, 28, 21, 14,
         7,  6, 13, 20, 27, 34, 41, 48
    };

    logic        clock;
    logic        reset_n;
    logic        decompress_start;
    logic        enc_data_ready;
    byte_t       enc_data;
    logic        dec_data_fifo_ready;
    logic        enc_data_req;
    coef_t       dec_data;
    logic        dec_data_en;
    scan_index_t dec_data_index;

    byte_t       stream_q [$];
    coef_t       exp_coef_q [$];
    scan_index_t exp_index_q [$];
    string       block_name_q [$];
    int          byte_ptr = 0;
    int          gap_from = 0;
    int          out_count = 0;

    entropy_decoder dut_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .decompress_start    (decompress_start),
        .enc_data_ready      (enc_data_ready),
        .enc_data            (enc_data),
        .dec_data_fifo_ready (dec_data_fifo_ready),
        .enc_data_req        (enc_data_req),
        .dec_data            (dec_data),
        .dec_data_en         (dec_data_en),
        .dec_data_index      (dec_data_index)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_coef(input string name, input coef_t expected, input coef_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED %s coefficient: expected %0d, actual %0d",
                                    name, expected, actual));
        end
    endtask

    task automatic check_index(input string name, input scan_index_t expected,
                               input scan_index_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED %s index: expected %0d, actual %0d",
                                    name, expected, actual));
        end
    endtask

    function automatic bit fits_width(input int value, input int width);
        return (value >= -(1 << (width - 1))) && (value < (1 << (width - 1)));
    endfunction

    // ------------------------------------------------------------------
    // Reference encoder, narrowest width per group of four values
    // ------------------------------------------------------------------
    function automatic void encode_block(input coef_t dc, input run_count_t run,
                                         input int vals [0:MAX_VALUES-1]);
        int    n;
        int    groups;
        int    words;
        int    acc;
        int    nbits;
        int    widths [0:15];
        byte_t word;
        n      = MAX_VALUES - int'(run);
        groups = (n + `GROUP_SIZE - 1) / `GROUP_SIZE;
        words  = (groups + `CODES_PER_WORD - 1) / `CODES_PER_WORD;
        stream_q.push_back({run, 2'b00});
        stream_q.push_back(byte_t'($urandom));
        stream_q.push_back(byte_t'(dc));
        for (int g = 0; g < groups; g++) begin
            widths[g] = 1;
            for (int i = g * `GROUP_SIZE; i < (g + 1) * `GROUP_SIZE && i < n; i++) begin
                while (!fits_width(vals[i], widths[g])) begin
                    widths[g]++;
                end
            end
        end
        for (int k = 0; k < words; k++) begin
            word = '0;
            for (int c = 0; c < `CODES_PER_WORD; c++) begin
                word = word << 2;
                if (k * `CODES_PER_WORD + c < groups) begin
                    word[1:0] = width_code_t'(widths[k * `CODES_PER_WORD + c] - 1);
                end
            end
            stream_q.push_back(word);
        end
        // Payload bits go out MSB first, last byte padded with zeros
        acc   = 0;
        nbits = 0;
        for (int i = 0; i < n; i++) begin
            for (int b = widths[i / `GROUP_SIZE] - 1; b >= 0; b--) begin
                acc = (acc << 1) | ((vals[i] >> b) & 1);
                nbits++;
                if (nbits == 8) begin
                    stream_q.push_back(byte_t'(acc));
                    acc   = 0;
                    nbits = 0;
                end
            end
        end
        if (nbits != 0) begin
            stream_q.push_back(byte_t'(acc << (8 - nbits)));
        end
    endfunction

    // ------------------------------------------------------------------
    // Reference decoder, returns the byte length of the block
    // ------------------------------------------------------------------
    function automatic int decode_block(input int base);
        int    run;
        int    n;
        int    words;
        int    pay;
        int    bitpos;
        int    width;
        int    value;
        byte_t hdr;
        byte_t code_byte;
        byte_t pay_byte;
        hdr    = stream_q[base];
        run    = int'(hdr[7:2]);
        n      = MAX_VALUES - run;
        words  = (n + CODES_PER_BYTE - 1) / CODES_PER_BYTE;
        pay    = base + `HEADER_BYTES + words;
        bitpos = 0;
        exp_index_q.push_back(scan_index_t'(SCAN_ORDER[0]));
        exp_coef_q.push_back(coef_t'(stream_q[base + 2]));
        for (int s = 1; s <= run; s++) begin
            exp_index_q.push_back(scan_index_t'(SCAN_ORDER[s]));
            exp_coef_q.push_back('0);
        end
        for (int i = 0; i < n; i++) begin
            code_byte = stream_q[base + `HEADER_BYTES + i / CODES_PER_BYTE];
            code_byte = code_byte >> (6 - 2 * ((i / `GROUP_SIZE) % `CODES_PER_WORD));
            width     = int'(code_byte[1:0]) + 1;
            value     = 0;
            for (int b = 0; b < width; b++) begin
                pay_byte = stream_q[pay + bitpos / 8];
                value    = (value << 1) | int'(pay_byte[7 - bitpos % 8]);
                bitpos++;
            end
            if (value >= (1 << (width - 1))) begin
                value = value - (1 << width);
            end
            exp_index_q.push_back(scan_index_t'(SCAN_ORDER[1 + run + i]));
            exp_coef_q.push_back(coef_t'(value));
        end
        return `HEADER_BYTES + words + (bitpos + 7) / 8;
    endfunction

    // Block 0 is all zeros after DC, block 1 has no zero run at all
    task automatic build_stream();
        int vals [0:MAX_VALUES-1];
        int run;
        int limit;
        int base;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            base  = stream_q.size();
            limit = 1;
            run   = (b == 0) ? MAX_VALUES : (b == 1) ? 0 : int'($urandom_range(62));
            for (int i = 0; i < MAX_VALUES; i++) begin
                if (i % `GROUP_SIZE == 0) begin
                    limit = 1 << (int'($urandom_range(4, 1)) - 1);
                end
                vals[i] = int'($urandom_range(2 * limit - 1)) - limit;
            end
            if (b == NUM_BLOCKS / 2) begin
                gap_from = base;
            end
            encode_block(coef_t'($urandom), run_count_t'(run), vals);
            if (decode_block(base) != stream_q.size() - base) begin
                stop_on_error("Reference decoder read a different block length than encoded");
            end
            if (b == 0) begin
                block_name_q.push_back("full_zero_run");
            end else begin
                block_name_q.push_back($sformatf("%s_block_%0d run %0d",
                    (b >= NUM_BLOCKS / 2) ? "gapped" : "random", b, run));
            end
        end
    endtask

    // Byte source, next byte offered after each taken one
    initial begin : drive_source
        logic took;
        enc_data       = '0;
        enc_data_ready = 1'b0;
        forever begin
            @(negedge clock);
            took = enc_data_req && enc_data_ready;
            @(posedge clock);
            #1;
            if (took) begin
                byte_ptr++;
            end
            if (byte_ptr < stream_q.size()) begin
                enc_data       = stream_q[byte_ptr];
                enc_data_ready = (byte_ptr < gap_from) ? 1'b1 : ($urandom_range(9) < 7);
            end else begin
                enc_data       = '0;
                enc_data_ready = 1'b0;
            end
        end
    end

    always @(negedge clock) begin : compare_outputs
        string name;
        if (reset_n && dec_data_en) begin
            if (exp_coef_q.size() == 0) begin
                stop_on_error("Decoder produced an output after all expected outputs");
            end else begin
                name = $sformatf("%s step %0d", block_name_q[0], out_count % `BLOCK_COEFS);
                check_index(name, exp_index_q.pop_front(), dec_data_index);
                check_coef(name, exp_coef_q.pop_front(), dec_data);
                out_count++;
                if (out_count % `BLOCK_COEFS == 0) begin
                    void'(block_name_q.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_on_error($sformatf("Timeout after %0d cycles with %0d outputs still due",
                                        cycles, exp_coef_q.size()));
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset_n             = 1'b0;
        decompress_start    = 1'b0;
        dec_data_fifo_ready = 1'b1;
        build_stream();
        repeat (2) @(posedge clock);
        #1 reset_n = 1'b1;

        // No start pulse yet, so the decoder must stay quiet
        repeat (20) begin
            @(negedge clock);
            if (enc_data_req || dec_data_en) begin
                stop_on_error("Decoder requested bytes or produced output before a start");
            end
        end

        @(posedge clock);
        #1;
        dec_data_fifo_ready = 1'b0;
        decompress_start    = 1'b1;
        @(posedge clock);
        #1 decompress_start = 1'b0;
        repeat (15) begin
            @(negedge clock);
            if (enc_data_req || dec_data_en) begin
                stop_on_error("Decoder took bytes or produced output while the FIFO was not ready");
            end
        end
        @(posedge clock);
        #1 dec_data_fifo_ready = 1'b1;

        while (exp_coef_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (20) @(posedge clock);
        // Source is empty now, so the decoder must wait without a request
        @(negedge clock);
        if (byte_ptr == stream_q.size() && !enc_data_req) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_on_error($sformatf("Decoder still busy at the end, %0d of %0d bytes taken",
                                    byte_ptr, stream_q.size()));
        end
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/entropy_decoder_pkg.sv
rtl/block_sequencer.sv
rtl/header_parser.sv
rtl/coefficient_unpacker.sv
rtl/coefficient_output.sv
rtl/entropy_decoder.sv
bench/tb_entropy_decoder.sv

// File: run.sh
#!/bin/sh
# Build the entropy decoder testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_entropy_decoder -o tb_sim \
    || { echo "Verilator build failed"; exit 1; }
sim_out="$(./obj_dir/tb_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "Finished with no errors" \
    && echo "SIMULATION PASSED" \
    || { echo "SIMULATION FAILED"; exit 1; }
